/* fme_refine.f */
source/fme_pkg.sv
source/fme_step_counter.sv
source/fme_ctrl.sv
source/fme_halfpel_interp.sv
source/fme_sad_bank.sv
source/fme_cost_select.sv
source/fme_top.sv
tb/fme_checker.sv
tb/fme_tb.sv

/* Makefile */
# Verilator flow for the half-pel refiner testbench
# Any variable can be overridden, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= fme_tb
FILELIST  ?= fme_refine.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check:
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS: $(LOG)" || \
		(echo "FAIL: see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/fme_tb.sv */
// Testbench for fme_top, one 8x8 block per table entry.
// Window and current memories answer a read on the next cycle.
// Pixel data stays fixed from start to done, the checker reads it at done.

`timescale 1ns/1ps

module fme_tb;

	localparam int BLK_SIZE     = 8;
	localparam int WIN          = BLK_SIZE + 2;
	localparam int NUM_TESTS    = 8;
	localparam int DONE_TIMEOUT = 40; // Cycles
	localparam int SEED         = 32'h33e1_3ad7;

	localparam int KIND_FLAT   = 0; // Every pixel equal
	localparam int KIND_RAND   = 1; // Independent window and block
	localparam int KIND_SHIFT  = 2; // Block is candidate 3 of a random window
	localparam int KIND_SMOOTH = 3; // Same, low contrast window

	typedef struct packed {
		logic [95:0] name;
		int          kind;
		int          seed_ofs;
		int          qp;
		int          mvx;
		int          mvy;
		int          poke;     // Second start while busy
		int          exp_idx;  // -1 leaves it to the model
		int          exp_cost; // -1 leaves it to the model
	} test_t;

	// **********************************************************************
	// Stimulus table
	// **********************************************************************

	localparam test_t TESTS [NUM_TESTS] = '{
		'{"flat_qp20",    KIND_FLAT,   0, 20,   12,   -7, 0,  0,  0},
		'{"flat_tie",     KIND_FLAT,   0,  0,    0,    0, 0,  0,  0},
		'{"rand_a",       KIND_RAND,   1,  0,    3,    5, 0, -1, -1},
		'{"rand_b",       KIND_RAND,   2,  0,   -8,    2, 0, -1, -1},
		'{"shift_lowqp",  KIND_SHIFT,  3,  3,    4,    4, 0,  3,  6},
		'{"shift_highqp", KIND_SMOOTH, 4, 63,   -2,   -6, 0,  0, -1},
		'{"neg_mv",       KIND_RAND,   5, 10, -300, -511, 0, -1, -1},
		'{"busy_start",   KIND_RAND,   6,  5,    7,   -1, 1, -1, -1}
	};

	logic                                 clk;
	logic                                 rstn;
	logic                                 start;
	fme_pkg::fme_mv_u                     imv;
	logic [5:0]                           qp;
	logic                                 busy;
	logic                                 done;
	logic                                 ref_rden;
	logic [3:0]                           ref_row_idx;
	logic                                 cur_rden;
	logic [$clog2(BLK_SIZE)-1:0]          cur_row_idx;
	fme_pkg::pel_t [WIN-1:0]              ref_row = '0;
	fme_pkg::pel_t [BLK_SIZE-1:0]         cur_row = '0;
	logic                                 fmv_wren;
	fme_pkg::fme_mv_u                     fmv_data;
	logic [fme_pkg::COST_WIDTH-1:0]       best_cost;

	fme_pkg::pel_t [WIN-1:0]      win_mem [WIN];
	fme_pkg::pel_t [BLK_SIZE-1:0] cur_mem [BLK_SIZE];
	logic [95:0]                  test_name;
	int                           exp_idx;
	int                           exp_cost;
	int                           tests_run;
	int                           errors;
	logic                         timed_out;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	fme_top #(.BLK_SIZE(BLK_SIZE)) fme_top_inst (
		.clk(clk), .rstn(rstn), .start_i(start), .imv_i(imv), .qp_i(qp),
		.busy_o(busy), .done_o(done),
		.ref_rden_o(ref_rden), .ref_row_idx_o(ref_row_idx), .ref_row_i(ref_row),
		.cur_rden_o(cur_rden), .cur_row_idx_o(cur_row_idx), .cur_row_i(cur_row),
		.fmv_wren_o(fmv_wren), .fmv_data_o(fmv_data), .best_cost_o(best_cost)
	);

	fme_checker #(.BLK_SIZE(BLK_SIZE)) fme_checker_inst (
		.clk(clk), .rstn(rstn), .start_i(start), .imv_i(imv), .qp_i(qp),
		.busy_i(busy), .done_i(done), .wren_i(fmv_wren),
		.ref_rden_i(ref_rden), .cur_rden_i(cur_rden),
		.fmv_i(fmv_data), .cost_i(best_cost),
		.name_i(test_name), .exp_idx_i(exp_idx), .exp_cost_i(exp_cost),
		.win_i(win_mem), .cur_i(cur_mem),
		.tests_o(tests_run), .errors_o(errors)
	);

	// Both memories answer one cycle after the read enable
	always @(posedge clk) begin
		if (ref_rden) begin
			ref_row <= win_mem[ref_row_idx];
		end
		if (cur_rden) begin
			cur_row <= cur_mem[cur_row_idx];
		end
	end

	task automatic fill_memories(input int kind, input int seed_ofs);
		integer seed;
		int     sum;
		seed = SEED + seed_ofs;
		for (int r = 0; r < WIN; r++) begin
			for (int c = 0; c < WIN; c++) begin
				if (kind == KIND_FLAT) begin
					win_mem[r][c] = fme_pkg::pel_t'(77);
				end else if (kind == KIND_SMOOTH) begin
					win_mem[r][c] = fme_pkg::pel_t'(128 + ($random(seed) & 1));
				end else begin
					win_mem[r][c] = fme_pkg::pel_t'($random(seed));
				end
			end
		end
		for (int r = 0; r < BLK_SIZE; r++) begin
			for (int c = 0; c < BLK_SIZE; c++) begin
				if (kind == KIND_FLAT) begin
					cur_mem[r][c] = fme_pkg::pel_t'(77);
				end else if (kind == KIND_RAND) begin
					cur_mem[r][c] = fme_pkg::pel_t'($random(seed));
				end else begin
					// Half pel up and right of integer pixel (r+1, c+1)
					sum = int'(win_mem[r][c+1]) + int'(win_mem[r][c+2]) +
					      int'(win_mem[r+1][c+1]) + int'(win_mem[r+1][c+2]);
					cur_mem[r][c] = fme_pkg::pel_t'((sum + 2) / 4);
				end
			end
		end
	endtask

	// Entered right after a rising edge, so drives land on that edge
	task automatic run_test(input test_t t);
		int waited;
		fill_memories(t.kind, t.seed_ofs);
		test_name = t.name;
		exp_idx   = t.exp_idx;
		exp_cost  = t.exp_cost;
		start   <= 1'b1;
		imv.raw <= {fme_pkg::FMV_WIDTH'(t.mvx), fme_pkg::FMV_WIDTH'(t.mvy)};
		qp      <= 6'(t.qp);
		@(posedge clk);
		start <= 1'b0;
		if (t.poke != 0) begin
			repeat (5) @(posedge clk);
			start   <= 1'b1; // Mid-block, must be dropped
			imv.raw <= '0;
			@(posedge clk);
			start <= 1'b0;
		end
		waited = 0;
		@(negedge clk);
		while (done !== 1'b1 && waited < DONE_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (done !== 1'b1) begin
			$display("timeout: no done from the DUT within %0d cycles in test %0s",
				DONE_TIMEOUT, t.name);
			timed_out = 1'b1;
		end
		@(posedge clk);
		repeat ((t.poke != 0) ? 30 : 2) @(posedge clk); // Room for a stray done
	endtask

	initial begin
		rstn      = 1'b0;
		start     = 1'b0;
		imv       = '0;
		qp        = '0;
		test_name = '0;
		exp_idx   = -1;
		exp_cost  = -1;
		timed_out = 1'b0;
		repeat (3) @(posedge clk);
		rstn <= 1'b1;
		repeat (2) @(posedge clk);
		for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
			run_test(TESTS[i]);
		end
		repeat (5) @(posedge clk);
		fme_checker_inst.print_summary();
		if (errors == 0 && !timed_out && tests_run == NUM_TESTS) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* tb/fme_checker.sv */
// Reference model and scoreboard for fme_top, one block in flight.
// Works on the testbench memories, read when done is seen.
// Latency is counted from the edge that accepts start.

`timescale 1ns/1ps

module fme_checker #(
	parameter int BLK_SIZE = 8,
	parameter int LATENCY  = 22
) (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            start_i,
	input  fme_pkg::fme_mv_u                imv_i,
	input  logic [5:0]                      qp_i,
	input  logic                            busy_i,
	input  logic                            done_i,
	input  logic                            wren_i,
	input  logic                            ref_rden_i,
	input  logic                            cur_rden_i,
	input  fme_pkg::fme_mv_u                fmv_i,
	input  logic [fme_pkg::COST_WIDTH-1:0]  cost_i,
	input  logic [95:0]                     name_i,
	input  int                              exp_idx_i,
	input  int                              exp_cost_i,
	input  fme_pkg::pel_t [BLK_SIZE+1:0]    win_i [BLK_SIZE+2],
	input  fme_pkg::pel_t [BLK_SIZE-1:0]    cur_i [BLK_SIZE],
	output int                              tests_o,
	output int                              errors_o
);

	// Half-pel offsets, center first
	localparam int OFS_X [9] = '{0, -1, 0, 1, -1, 1, -1, 0, 1};
	localparam int OFS_Y [9] = '{0, -1, -1, -1, 0, 0, 1, 1, 1};

	logic             pending = 1'b0;
	int               cyc = 0;
	int               n_tests = 0;
	int               n_failed = 0;
	int               n_errors = 0;
	int               err_start;
	fme_pkg::fme_mv_u cap_mv;
	int               cap_qp;
	int               cap_idx;
	int               cap_cost;
	logic [95:0]      cap_name;

	assign tests_o  = n_tests;
	assign errors_o = n_errors;

	// Window sample at doubled coordinates, odd means halfway
	function automatic int sample(input int y2, input int x2);
		int y;
		int x;
		y = y2 / 2;
		x = x2 / 2;
		if (y2 % 2 == 0 && x2 % 2 == 0) begin
			return int'(win_i[y][x]);
		end else if (y2 % 2 == 0) begin
			return (int'(win_i[y][x]) + int'(win_i[y][x+1]) + 1) / 2;
		end else if (x2 % 2 == 0) begin
			return (int'(win_i[y][x]) + int'(win_i[y+1][x]) + 1) / 2;
		end
		return (int'(win_i[y][x]) + int'(win_i[y][x+1]) +
		        int'(win_i[y+1][x]) + int'(win_i[y+1][x+1]) + 2) / 4;
	endfunction

	// Block pixel (r, c) sits on window pixel (r+1, c+1)
	function automatic int model_sad(input int g);
		int s;
		int d;
		s = 0;
		for (int r = 0; r < BLK_SIZE; r++) begin
			for (int c = 0; c < BLK_SIZE; c++) begin
				d = sample(2 * r + 2 + OFS_Y[g], 2 * c + 2 + OFS_X[g]) - int'(cur_i[r][c]);
				s += (d < 0) ? -d : d;
			end
		end
		return s;
	endfunction

	task automatic compare_mv(input string what, input int idx);
		fme_pkg::fme_mv_u exp_mv;
		exp_mv.f.x = fme_pkg::FMV_WIDTH'(cap_mv.f.x + OFS_X[idx]);
		exp_mv.f.y = fme_pkg::FMV_WIDTH'(cap_mv.f.y + OFS_Y[idx]);
		if (fmv_i.raw !== exp_mv.raw) begin
			$display("error %0s %0s fmv expected (%0d,%0d) actual (%0d,%0d)", cap_name, what,
				exp_mv.f.x, exp_mv.f.y, fmv_i.f.x, fmv_i.f.y);
			n_errors++;
		end
	endtask

	task automatic compare_val(input string what, input int exp_val, input int act_val);
		if (exp_val != act_val) begin
			$display("error %0s %0s expected %0d actual %0d", cap_name, what, exp_val, act_val);
			n_errors++;
		end
	endtask

	task automatic check_result();
		int cost;
		int nz;
		int best_cost;
		int best_idx;
		best_cost = 1 << 30;
		best_idx  = 0;
		for (int g = 0; g < 9; g++) begin
			nz   = int'(OFS_X[g] != 0) + int'(OFS_Y[g] != 0);
			cost = model_sad(g) + cap_qp * nz;
			if (cost < best_cost) begin // Tie keeps the lower index
				best_cost = cost;
				best_idx  = g;
			end
		end
		compare_mv("model", best_idx);
		compare_val("cost", best_cost, int'(cost_i));
		if (cap_idx >= 0) begin
			compare_mv("table", cap_idx);
		end
		if (cap_cost >= 0) begin
			compare_val("table cost", cap_cost, int'(cost_i));
		end
	endtask

	// **********************************************************************
	// Bus watch, sampled on the rising edge like the DUT
	// **********************************************************************

	always @(posedge clk) begin
		if (rstn) begin
			if (busy_i !== pending) begin
				$display("busy flag does not match the block in flight");
				n_errors++;
			end
			if (wren_i !== done_i) begin
				$display("fmv write enable does not match done");
				n_errors++;
			end
			if (pending) begin
				cyc++;
				if (done_i) begin
					compare_val("latency", LATENCY, cyc);
					check_result();
					pending = 1'b0;
					n_tests++;
					if (n_errors != err_start) begin
						n_failed++;
					end
					$display("test %0s: %0s", cap_name, (n_errors == err_start) ? "ok" : "FAILED");
				end
			end else begin
				if (ref_rden_i || cur_rden_i) begin
					$display("read enable high while no block is in flight");
					n_errors++;
				end
				if (done_i) begin
					$display("done pulsed with no block in flight");
					n_errors++;
				end
				if (start_i) begin // Taken only when idle
					pending   = 1'b1;
					cyc       = 0;
					err_start = n_errors;
					cap_mv    = imv_i;
					cap_qp    = int'(qp_i);
					cap_idx   = exp_idx_i;
					cap_cost  = exp_cost_i;
					cap_name  = name_i;
				end
			end
		end
	end

	task automatic print_summary();
		$display("%0d tests run, %0d ok, %0d failed, %0d errors in total",
			n_tests, n_tests - n_failed, n_failed, n_errors);
	endtask

endmodule

/* source/fme_top.sv */
// Half-pel refiner for one block per start, fixed latency of 22 cycles.
// Both memories must answer a read on the next cycle, no back-pressure.
// A start while busy is dropped.

`timescale 1ns/1ps

module fme_top #(
	parameter int BLK_SIZE = 8
) (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  logic                                 start_i,
	input  fme_pkg::fme_mv_u                     imv_i,
	input  logic [5:0]                           qp_i,
	output logic                                 busy_o,
	output logic                                 done_o,
	output logic                                 ref_rden_o,
	output logic [3:0]                           ref_row_idx_o,
	input  fme_pkg::pel_t [BLK_SIZE+1:0]         ref_row_i,
	output logic                                 cur_rden_o,
	output logic [$clog2(BLK_SIZE)-1:0]          cur_row_idx_o,
	input  fme_pkg::pel_t [BLK_SIZE-1:0]         cur_row_i,
	output logic                                 fmv_wren_o,
	output fme_pkg::fme_mv_u                     fmv_data_o,
	output logic [fme_pkg::COST_WIDTH-1:0]       best_cost_o
);

	logic [3:0] count;
	logic [3:0] limit;
	logic       last;
	logic       clear;
	logic       step;
	logic       interp_en;
	logic       accum_clr;
	logic       accum_en;
	logic       search_clr;
	logic       search_en;
	logic       row_valid;
	logic       first;

	fme_pkg::pel_t [2:0][BLK_SIZE-1:0]                       int_rows;
	fme_pkg::pel_t [2:0][BLK_SIZE-1:0]                       half_rows;
	logic [fme_pkg::NUM_CANDI-1:0][fme_pkg::SAD_WIDTH-1:0]   sad;

	assign fmv_wren_o = done_o; // Result write strobe is the done pulse

	fme_ctrl #(.BLK_SIZE(BLK_SIZE)) fme_ctrl_inst (
		.clk(clk), .rstn(rstn), .start_i(start_i),
		.count_i(count), .last_i(last),
		.clear_o(clear), .step_o(step), .limit_o(limit),
		.busy_o(busy_o), .done_o(done_o),
		.ref_rden_o(ref_rden_o), .ref_row_idx_o(ref_row_idx_o),
		.cur_rden_o(cur_rden_o), .cur_row_idx_o(cur_row_idx_o),
		.interp_en_o(interp_en), .accum_clr_o(accum_clr), .accum_en_o(accum_en),
		.search_clr_o(search_clr), .search_en_o(search_en)
	);

	fme_step_counter fme_step_counter_inst (
		.clk(clk), .rstn(rstn), .clear_i(clear), .step_i(step),
		.limit_i(limit), .count_o(count), .last_o(last)
	);

	fme_halfpel_interp #(.BLK_SIZE(BLK_SIZE)) fme_halfpel_interp_inst (
		.clk(clk), .rstn(rstn), .en_i(interp_en), .ref_row_i(ref_row_i),
		.row_valid_o(row_valid), .first_o(first),
		.int_rows_o(int_rows), .half_rows_o(half_rows)
	);

	fme_sad_bank #(.BLK_SIZE(BLK_SIZE)) fme_sad_bank_inst (
		.clk(clk), .rstn(rstn), .clr_i(accum_clr), .en_i(accum_en),
		.row_valid_i(row_valid), .first_i(first),
		.int_rows_i(int_rows), .half_rows_i(half_rows),
		.cur_row_i(cur_row_i), .sad_o(sad)
	);

	fme_cost_select fme_cost_select_inst (
		.clk(clk), .rstn(rstn), .clr_i(search_clr), .en_i(search_en),
		.idx_i(count), .qp_i(qp_i), .imv_i(imv_i), .sad_i(sad),
		.best_mv_o(fmv_data_o), .best_cost_o(best_cost_o)
	);

endmodule

/* source/fme_cost_select.sv */
// Walks the candidates one per cycle and keeps the cheapest.
// Cost is SAD plus qp per nonzero offset component.
// Only a strictly lower cost replaces the best, so ties keep the lower index.

`timescale 1ns/1ps

module fme_cost_select (
	input  logic                                                   clk,
	input  logic                                                   rstn,
	input  logic                                                   clr_i,
	input  logic                                                   en_i,
	input  logic [3:0]                                             idx_i,
	input  logic [5:0]                                             qp_i,
	input  fme_pkg::fme_mv_u                                       imv_i,
	input  logic [fme_pkg::NUM_CANDI-1:0][fme_pkg::SAD_WIDTH-1:0]  sad_i,
	output fme_pkg::fme_mv_u                                       best_mv_o,
	output logic [fme_pkg::COST_WIDTH-1:0]                         best_cost_o
);

	fme_pkg::fme_mv_u                imv_q;
	fme_pkg::fme_mv_u                cand_mv;
	logic [5:0]                      qp_q;
	logic [1:0]                      nz;
	logic [fme_pkg::COST_WIDTH-1:0]  cost;
	int                              cand_dx;
	int                              cand_dy;

	// Start inputs captured with the clear
	always_ff @(posedge clk) begin
		if (clr_i) begin
			imv_q.raw <= imv_i.raw;
			qp_q      <= qp_i;
		end
	end

	assign cand_dx = fme_pkg::CANDI_DX[idx_i];
	assign cand_dy = fme_pkg::CANDI_DY[idx_i];
	assign nz      = 2'(cand_dx != 0) + 2'(cand_dy != 0);

	assign cost = fme_pkg::COST_WIDTH'(sad_i[idx_i]) +
	              fme_pkg::COST_WIDTH'(qp_q) * fme_pkg::COST_WIDTH'(nz);

	assign cand_mv.f.x = imv_q.f.x + fme_pkg::FMV_WIDTH'(cand_dx);
	assign cand_mv.f.y = imv_q.f.y + fme_pkg::FMV_WIDTH'(cand_dy);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			best_cost_o <= '1;
			best_mv_o   <= '0;
		end else if (clr_i) begin
			best_cost_o <= '1; // Center always beats this
		end else if (en_i && (cost < best_cost_o)) begin
			best_cost_o <= cost;
			best_mv_o   <= cand_mv;
		end
	end

	a_idx_range: assert property (@(posedge clk) disable iff (!rstn)
		en_i |-> idx_i < 4'(fme_pkg::NUM_CANDI));

endmodule

/* source/fme_sad_bank.sv */
// Nine SAD accumulators fed one interpolated row per cycle.
// Reference row k pairs with current rows k-1 and k-2, the latter
// taken from a two-deep delay on the current-row bus.
// Sums hold until the next clear.

`timescale 1ns/1ps

module fme_sad_bank #(
	parameter int BLK_SIZE = 8
) (
	input  logic                                                   clk,
	input  logic                                                   rstn,
	input  logic                                                   clr_i,
	input  logic                                                   en_i,
	input  logic                                                   row_valid_i,
	input  logic                                                   first_i,
	input  fme_pkg::pel_t [2:0][BLK_SIZE-1:0]                      int_rows_i,
	input  fme_pkg::pel_t [2:0][BLK_SIZE-1:0]                      half_rows_i,
	input  fme_pkg::pel_t [BLK_SIZE-1:0]                           cur_row_i,
	output logic [fme_pkg::NUM_CANDI-1:0][fme_pkg::SAD_WIDTH-1:0]  sad_o
);

	fme_pkg::pel_t [BLK_SIZE-1:0] cur_q1; // Current row k-1
	fme_pkg::pel_t [BLK_SIZE-1:0] cur_q2; // Current row k-2
	logic [3:0]                   row_k;
	logic [3:0]                   k_now;
	logic                         acc;

	function automatic logic [fme_pkg::SAD_WIDTH-1:0] row_sad(
			input fme_pkg::pel_t [BLK_SIZE-1:0] a, input fme_pkg::pel_t [BLK_SIZE-1:0] b);
		logic [fme_pkg::SAD_WIDTH-1:0] s;
		s = '0;
		for (int i = 0; i < BLK_SIZE; i++) begin
			s = s + ((a[i] > b[i]) ? a[i] - b[i] : b[i] - a[i]);
		end
		return s;
	endfunction

	assign acc   = en_i && row_valid_i;
	assign k_now = first_i ? 4'd1 : row_k + 4'd1;

	always_ff @(posedge clk) begin
		cur_q1 <= cur_row_i;
		cur_q2 <= cur_q1;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			row_k <= 4'd0;
		end else if (acc) begin
			row_k <= k_now;
		end
	end

	// **********************************************************************
	// One accumulator per candidate, source picked by its offset
	// **********************************************************************

	for (genvar g = 0; g < fme_pkg::NUM_CANDI; g++) begin : g_candi
		localparam int DX = fme_pkg::CANDI_DX[g];
		localparam int DY = fme_pkg::CANDI_DY[g];

		logic [fme_pkg::SAD_WIDTH-1:0] rs;
		logic                          add;

		if (DY == 0) begin : g_int
			assign rs  = row_sad(int_rows_i[DX+1], cur_q1);
			assign add = acc && (k_now <= 4'(BLK_SIZE));
		end else if (DY < 0) begin : g_up
			assign rs  = row_sad(half_rows_i[DX+1], cur_q1);
			assign add = acc && (k_now <= 4'(BLK_SIZE));
		end else begin : g_down
			assign rs  = row_sad(half_rows_i[DX+1], cur_q2);
			assign add = acc && (k_now >= 4'd2);
		end

		always_ff @(posedge clk or negedge rstn) begin
			if (!rstn) begin
				sad_o[g] <= '0;
			end else if (clr_i) begin
				sad_o[g] <= '0;
			end else if (add) begin
				sad_o[g] <= sad_o[g] + rs;
			end
		end

		a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
			add |-> ({1'b0, sad_o[g]} + {1'b0, rs}) < (1 << fme_pkg::SAD_WIDTH));
	end

endmodule

/* source/fme_halfpel_interp.sv */
// Rounded bilinear half-pel rows from two consecutive window rows.
// Needs en_i high for consecutive rows of one window, no gaps.
// Output column c lines up with integer window column c+1.

`timescale 1ns/1ps

module fme_halfpel_interp #(
	parameter int BLK_SIZE = 8
) (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  logic                                 en_i,
	input  fme_pkg::pel_t [BLK_SIZE+1:0]         ref_row_i,
	output logic                                 row_valid_o,
	output logic                                 first_o,
	output fme_pkg::pel_t [2:0][BLK_SIZE-1:0]    int_rows_o,
	output fme_pkg::pel_t [2:0][BLK_SIZE-1:0]    half_rows_o
);

	fme_pkg::pel_t [BLK_SIZE+1:0]      prev_row;
	fme_pkg::pel_t [2:0][BLK_SIZE-1:0] int_nxt;
	fme_pkg::pel_t [2:0][BLK_SIZE-1:0] half_nxt;
	logic                              have_prev;

	function automatic fme_pkg::pel_t avg2(input fme_pkg::pel_t a, input fme_pkg::pel_t b);
		logic [fme_pkg::PIXEL_WIDTH:0] s;
		s = {1'b0, a} + {1'b0, b} + 1'b1;
		return s[fme_pkg::PIXEL_WIDTH:1];
	endfunction

	function automatic fme_pkg::pel_t avg4(input fme_pkg::pel_t a, input fme_pkg::pel_t b,
			input fme_pkg::pel_t c, input fme_pkg::pel_t d);
		logic [fme_pkg::PIXEL_WIDTH+1:0] s;
		s = {2'b0, a} + {2'b0, b} + {2'b0, c} + {2'b0, d} + 2'd2;
		return s[fme_pkg::PIXEL_WIDTH+1:2];
	endfunction

	for (genvar c = 0; c < BLK_SIZE; c++) begin : g_col
		// dx -1, 0, +1 on the current row
		assign int_nxt[0][c]  = avg2(ref_row_i[c], ref_row_i[c+1]);
		assign int_nxt[1][c]  = ref_row_i[c+1];
		assign int_nxt[2][c]  = avg2(ref_row_i[c+1], ref_row_i[c+2]);
		// Same three, halfway between previous and current row
		assign half_nxt[0][c] = avg4(prev_row[c], prev_row[c+1], ref_row_i[c], ref_row_i[c+1]);
		assign half_nxt[1][c] = avg2(prev_row[c+1], ref_row_i[c+1]);
		assign half_nxt[2][c] = avg4(prev_row[c+1], prev_row[c+2],
			ref_row_i[c+1], ref_row_i[c+2]);
	end

	always_ff @(posedge clk) begin
		if (en_i) begin
			prev_row    <= ref_row_i;
			int_rows_o  <= int_nxt;
			half_rows_o <= half_nxt;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			have_prev   <= 1'b0;
			row_valid_o <= 1'b0;
			first_o     <= 1'b0;
		end else begin
			have_prev   <= en_i;
			row_valid_o <= en_i && have_prev;
			first_o     <= en_i && have_prev && !row_valid_o; // Window row 1
		end
	end

endmodule

/* source/fme_ctrl.sv */
// Sequencer for one block: window read, pipeline drain, candidate search.
// The shared step counter counts rows, then drain cycles, then candidates.
// Current row r is fetched together with reference row r+1.

`timescale 1ns/1ps

module fme_ctrl #(
	parameter int BLK_SIZE = 8
) (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          start_i,
	input  logic [3:0]                    count_i,
	input  logic                          last_i,
	output logic                          clear_o,
	output logic                          step_o,
	output logic [3:0]                    limit_o,
	output logic                          busy_o,
	output logic                          done_o,
	output logic                          ref_rden_o,
	output logic [3:0]                    ref_row_idx_o,
	output logic                          cur_rden_o,
	output logic [$clog2(BLK_SIZE)-1:0]   cur_row_idx_o,
	output logic                          interp_en_o,
	output logic                          accum_clr_o,
	output logic                          accum_en_o,
	output logic                          search_clr_o,
	output logic                          search_en_o
);

	localparam logic [2:0] ST_IDLE   = 3'd0;
	localparam logic [2:0] ST_READ   = 3'd1;
	localparam logic [2:0] ST_DRAIN  = 3'd2;
	localparam logic [2:0] ST_SEARCH = 3'd3;
	localparam logic [2:0] ST_DONE   = 3'd4;
	localparam int CUR_IDX_W = $clog2(BLK_SIZE);

	logic [2:0] state_q;
	logic [2:0] state_d;
	logic       start_acc;
	logic       counting;
	logic       rden_q;
	logic       rden_d1;
	logic       rden_d2;

	assign start_acc = (state_q == ST_IDLE) && start_i;
	assign counting  = (state_q == ST_READ) || (state_q == ST_DRAIN) ||
	                   (state_q == ST_SEARCH);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:   if (start_i) state_d = ST_READ;
			ST_READ:   if (last_i) state_d = ST_DRAIN;
			ST_DRAIN:  if (last_i) state_d = ST_SEARCH; // Two cycles for interp and SAD stages
			ST_SEARCH: if (last_i) state_d = ST_DONE;
			default:   state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Count limit of each phase
	always_comb begin
		case (state_q)
			ST_READ:   limit_o = 4'(BLK_SIZE + 1);
			ST_DRAIN:  limit_o = 4'd1;
			ST_SEARCH: limit_o = 4'(fme_pkg::NUM_CANDI - 1);
			default:   limit_o = 4'd0;
		endcase
	end

	assign clear_o = start_acc || (counting && last_i);
	assign step_o  = counting;

	// **********************************************************************
	// Read strobe and its delayed copies
	// **********************************************************************

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			rden_q  <= 1'b0;
			rden_d1 <= 1'b0;
			rden_d2 <= 1'b0;
		end else begin
			rden_q  <= start_acc || (rden_q && !last_i);
			rden_d1 <= rden_q;  // Reference data on the bus
			rden_d2 <= rden_d1; // Interpolated rows ready
		end
	end

	assign ref_rden_o    = rden_q;
	assign ref_row_idx_o = count_i;
	assign cur_rden_o    = rden_q && (count_i != 4'd0) && (count_i <= 4'(BLK_SIZE));
	assign cur_row_idx_o = CUR_IDX_W'(count_i - 4'd1);

	assign interp_en_o  = rden_d1;
	assign accum_en_o   = rden_d2;
	assign accum_clr_o  = start_acc;
	assign search_clr_o = start_acc;
	assign search_en_o  = (state_q == ST_SEARCH);
	assign busy_o       = (state_q != ST_IDLE);
	assign done_o       = (state_q == ST_DONE);

	// Strobe flop and FSM must agree on the read phase
	a_rden_in_read: assert property (@(posedge clk) disable iff (!rstn)
		ref_rden_o |-> state_q == ST_READ);

endmodule

/* source/fme_step_counter.sv */
// Up counter from zero with a compare against a run-time limit.
// Clear wins over step.

`timescale 1ns/1ps

module fme_step_counter (
	input  logic       clk,
	input  logic       rstn,
	input  logic       clear_i,
	input  logic       step_i,
	input  logic [3:0] limit_i,
	output logic [3:0] count_o,
	output logic       last_o
);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			count_o <= 4'd0;
		end else if (clear_i) begin
			count_o <= 4'd0;
		end else if (step_i) begin
			count_o <= count_o + 4'd1;
		end
	end

	assign last_o = (count_o == limit_i); // Terminal step of the phase

endmodule

/* source/fme_pkg.sv */
// Shared constants and types for the half-pel refiner.
// Vector components are signed and counted in half-pel units.
// Candidate order is fixed by the offset tables below.

package fme_pkg;

	localparam int PIXEL_WIDTH = 8;
	localparam int FMV_WIDTH   = 10; // One signed component
	localparam int SAD_WIDTH   = 14; // Holds 64 * 255
	localparam int COST_WIDTH  = 16;
	localparam int NUM_CANDI   = 9;

	typedef logic [PIXEL_WIDTH-1:0] pel_t;

	// Vector word, moved raw or split into its components
	typedef union packed {
		logic [2*FMV_WIDTH-1:0] raw;
		struct packed {
			logic signed [FMV_WIDTH-1:0] x;
			logic signed [FMV_WIDTH-1:0] y;
		} f;
	} fme_mv_u;

	// **********************************************************************
	// Candidate offsets around the integer vector, in half pels
	// **********************************************************************

	// Index 0 is the center, so a tie keeps the integer vector
	localparam int CANDI_DX [NUM_CANDI] = '{
		0, -1, 0, 1,
		-1, 1,
		-1, 0, 1
	};

	localparam int CANDI_DY [NUM_CANDI] = '{
		0, -1, -1, -1,
		0, 0,
		1, 1, 1
	};

endpackage
